// File: Makefile
VERILATOR ?= verilator
TOP       ?= rdma_flow_top_tb
FILELIST  ?= rdma_flow_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/rdma_flow_checker.sv
`timescale 1ns/1ps

module rdma_flow_checker
    import rdma_meta_pkg::*;
(
    input logic      aclk,
    input logic      aresetn,
    input logic      s_req_valid,
    input logic      s_req_ready,
    input logic      m_req_valid,
    input logic      m_req_ready,
    input rdma_req_t m_req_data,
    input logic      s_ack_valid,
    input logic      s_ack_ready,
    input logic      m_ack_valid,
    input logic      m_ack_ready,
    input rdma_ack_t m_ack_data
);

    logic [5:0] since_reset;

    // Cycles since reset release, saturating once the sweep is over
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            since_reset <= '0;
        end else if (since_reset < 6'd32) begin
            since_reset <= since_reset + 1'b1;
        end
    end

    quiet_during_sweep: assert property (@(posedge aclk) disable iff (!aresetn)
        (since_reset < 6'd32) |-> !m_req_valid && !m_ack_valid && !s_req_ready && !s_ack_ready)
        else $error("Stream active during table sweep");

    m_req_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        m_req_valid && !m_req_ready |=> m_req_valid && $stable(m_req_data))
        else $error("m_req changed under back-pressure");

    m_ack_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        m_ack_valid && !m_ack_ready |=> m_ack_valid && $stable(m_ack_data))
        else $error("m_ack changed under back-pressure");

    // Input is consumed only together with the issued request
    s_req_with_issue: assert property (@(posedge aclk) disable iff (!aresetn)
        s_req_ready |-> s_req_valid && m_req_valid && m_req_ready)
        else $error("s_req accepted without an m_req transfer");

    s_ack_only_valid: assert property (@(posedge aclk) disable iff (!aresetn)
        s_ack_ready |-> s_ack_valid)
        else $error("s_ack_ready high without a pending ack");

endmodule

bind rdma_flow_top rdma_flow_checker rdma_flow_checker_i (.*);

// File: bench/rdma_flow_top_tb.sv
`timescale 1ns/1ps

`include "rdma_settings.svh"

module rdma_flow_top_tb
    import rdma_meta_pkg::*;
;

    localparam int N_DIRECTED  = 11;
    localparam int N_RAND      = 300;
    localparam int WORST_CYC   = 60;
    // Each request is matched by one ack, both may wait on random ready
    localparam int CYCLE_LIMIT = 32 + 8 + (N_DIRECTED + N_RAND) * 2 * WORST_CYC;
    localparam int WIN         = `RDMA_N_OUTSTANDING;

    logic      aclk;
    logic      aresetn;
    logic      s_req_valid;
    logic      s_req_ready;
    rdma_req_t s_req_data;
    logic      m_req_valid;
    logic      m_req_ready;
    rdma_req_t m_req_data;
    logic      s_ack_valid;
    logic      s_ack_ready;
    rdma_ack_t s_ack_data;
    logic      m_ack_valid;
    logic      m_ack_ready;
    rdma_ack_t m_ack_data;

    logic [31:0] lcg_state = 32'hbdc;
    logic        rand_ready;
    logic        req_done;
    int          cycles;
    int          value_errors;
    int          other_errors;
    int          req_xfers;
    int          ack_out_xfers;
    int          last_sent;
    int          issued [32];
    int          acked [32];
    rdma_ack_t   exp_acks [$];

    rdma_flow_top rdma_flow_top_i (.*);

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Read requests and read responses share a session
    function automatic int session_of(opcode_t op, region_t region, pid_t pid);
        logic rd;
        rd = (op == OP_RD_REQ) || (op == OP_RD_RESP);
        return int'({rd, region, pid});
    endfunction

    function automatic int total_outstanding();
        int sum;
        sum = 0;
        for (int i = 0; i < 32; i++) begin
            sum += issued[i] - acked[i];
        end
        return sum;
    endfunction

    task automatic check_value(string name, int got, int exp);
        assert (got == exp) else begin
            value_errors++;
            $display("Fail %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic send_req(rdma_req_t r);
        @(posedge aclk);
        s_req_valid <= 1'b1;
        s_req_data  <= r;
        do @(negedge aclk); while (!s_req_ready);
        @(posedge aclk);
        s_req_valid <= 1'b0;
    endtask

    task automatic send_ack(rdma_ack_t a);
        if (a.last) begin
            last_sent++;
        end
        @(posedge aclk);
        s_ack_valid <= 1'b1;
        s_ack_data  <= a;
        do @(negedge aclk); while (!s_ack_ready);
        @(posedge aclk);
        s_ack_valid <= 1'b0;
    endtask

    function automatic rdma_req_t make_req(logic rd, region_t region, pid_t pid);
        rdma_req_t r;
        r.opcode = rd ? OP_RD_REQ : OP_WR_REQ;
        r.region = region;
        r.pid    = pid;
        r.len    = 16'(next_rand() >> 16);
        r.offs   = 8'(next_rand() >> 24);
        return r;
    endfunction

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        if (rand_ready) begin
            m_req_ready <= (next_rand() >> 30) != 0;
            m_ack_ready <= (next_rand() >> 30) != 0;
        end else begin
            m_req_ready <= 1'b1;
            m_ack_ready <= 1'b1;
        end
    end

    // Scoreboard, sampled away from the clock edge
    always @(negedge aclk) begin
        int s;
        rdma_ack_t e;
        if (aresetn) begin
            if (m_req_valid && m_req_ready) begin
                s = session_of(m_req_data.opcode, m_req_data.region, m_req_data.pid);
                check_value("m_req_data.opcode", int'(m_req_data.opcode),
                            int'(s_req_data.opcode));
                check_value("m_req_data.len", int'(m_req_data.len), int'(s_req_data.len));
                check_value("m_req_data.pid", int'(m_req_data.pid), int'(s_req_data.pid));
                check_value("m_req_data.region", int'(m_req_data.region),
                            int'(s_req_data.region));
                check_value("m_req_data.offs", int'(m_req_data.offs), issued[s] % WIN);
                assert (issued[s] - acked[s] < WIN) else begin
                    other_errors++;
                    $display("Request left session %0d with its window already full", s);
                end
                issued[s]++;
                req_xfers++;
            end
            if (s_ack_valid && s_ack_ready) begin
                s = session_of(s_ack_data.opcode, s_ack_data.region, s_ack_data.pid);
                acked[s]++;
                if (s_ack_data.last) begin
                    exp_acks.push_back(s_ack_data);
                end
            end
            if (m_ack_valid && m_ack_ready) begin
                ack_out_xfers++;
                assert (exp_acks.size() > 0) else begin
                    other_errors++;
                    $display("Ack left the queue with none expected");
                end
                if (exp_acks.size() > 0) begin
                    e = exp_acks.pop_front();
                    check_value("m_ack_data", int'(m_ack_data), int'(e));
                end
            end
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int snap;
        int s;
        logic [31:0] r;
        rdma_ack_t a;
        aresetn     = 1'b0;
        s_req_valid = 1'b0;
        s_req_data  = '0;
        s_ack_valid = 1'b0;
        s_ack_data  = '0;
        m_req_ready = 1'b0;
        m_ack_ready = 1'b0;
        rand_ready  = 1'b0;
        req_done    = 1'b0;
        repeat (2) @(posedge aclk);
        aresetn <= 1'b1;

        // Fill one write window, then a read on the same region and pid
        for (int i = 0; i < WIN; i++) begin
            send_req(make_req(1'b0, 1'b0, 3'd1));
        end
        send_req(make_req(1'b1, 1'b0, 3'd1));
        send_req(make_req(1'b0, 1'b1, 3'd5));

        snap = req_xfers;
        fork
            send_req(make_req(1'b0, 1'b0, 3'd1));
            begin
                repeat (40) @(posedge aclk);
                check_value("m_req transfers while window full", req_xfers, snap);
                send_ack('{opcode: OP_WR_ACK, region: 1'b0, pid: 3'd1, last: 1'b1});
            end
        join

        // Random traffic under back-pressure, acks only for open slots
        rand_ready <= 1'b1;
        fork
            begin
                for (int i = 0; i < N_RAND; i++) begin
                    r = next_rand();
                    send_req(make_req(r[31], r[30], {1'b0, r[29:28]}));
                end
                req_done = 1'b1;
            end
            while (!req_done || total_outstanding() > 0) begin
                s = (next_rand() >> 27);
                for (int k = 0; k < 32 && issued[s] == acked[s]; k++) begin
                    s = (s + 1) % 32;
                end
                if (issued[s] > acked[s]) begin
                    a.opcode = s[4] ? OP_RD_RESP : OP_WR_ACK;
                    a.region = s[3];
                    a.pid    = s[2:0];
                    a.last   = 1'(next_rand() >> 31);
                    send_ack(a);
                end else begin
                    @(posedge aclk);
                end
            end
        join

        rand_ready <= 1'b0;
        while (exp_acks.size() > 0) begin
            @(posedge aclk);
        end
        repeat (4) @(posedge aclk);
        check_value("m_req transfer count", req_xfers, N_DIRECTED + N_RAND);
        check_value("m_ack transfer count", ack_out_xfers, last_sent);

        $display("Checks done: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: common/rdma_flow_pkg.sv
package rdma_flow_pkg;

    import rdma_meta_pkg::*;

    `include "rdma_settings.svh"

    typedef logic [$clog2(`RDMA_N_OUTSTANDING)-1:0] slot_t;

    typedef struct packed {
        logic    rd;
        region_t region;
        pid_t    pid;
    } session_key_t;

    localparam int N_SESSIONS = 1 << $bits(session_key_t);

    typedef struct packed {
        logic  issued;
        slot_t head;
        slot_t tail;
    } session_entry_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACK_WAIT,
        ST_REQ_WAIT,
        ST_ACK_UPDATE,
        ST_REQ_ISSUE
    } flow_state_t;

endpackage

// File: common/rdma_meta_pkg.sv
package rdma_meta_pkg;

    `include "rdma_settings.svh"

    typedef logic [`RDMA_PID_BITS-1:0]    pid_t;
    typedef logic [`RDMA_REGION_BITS-1:0] region_t;
    typedef logic [4:0]                   opcode_t;
    typedef logic [7:0]                   offs_t;

    // Base transport opcodes seen by the flow stage
    localparam opcode_t OP_RD_REQ  = 5'h0c;
    localparam opcode_t OP_WR_REQ  = 5'h0a;
    localparam opcode_t OP_RD_RESP = 5'h10;
    localparam opcode_t OP_WR_ACK  = 5'h11;

    typedef struct packed {
        opcode_t     opcode;
        region_t     region;
        pid_t        pid;
        logic [15:0] len;
        offs_t       offs;
    } rdma_req_t;

    typedef struct packed {
        opcode_t opcode;
        region_t region;
        pid_t    pid;
        logic    last;
    } rdma_ack_t;

    // Reads and their responses share one session
    function automatic logic is_read_op(opcode_t op);
        return (op == OP_RD_REQ) || (op == OP_RD_RESP);
    endfunction

endpackage

// File: common/rdma_settings.svh
`ifndef RDMA_SETTINGS_SVH
`define RDMA_SETTINGS_SVH

// Requests in flight allowed per session
`define RDMA_N_OUTSTANDING 8

// Process id width
`define RDMA_PID_BITS 3

// Region number width
`define RDMA_REGION_BITS 1

// Entries in the completion ack queue
`define RDMA_ACK_QDEPTH 8

`endif

// File: rdma_flow/rdma_flow.sv
`timescale 1ns/1ps

module rdma_flow
    import rdma_meta_pkg::*, rdma_flow_pkg::*;
(
    input  logic           aclk,
    input  logic           aresetn,

    input  logic           s_req_valid,
    output logic           s_req_ready,
    input  rdma_req_t      s_req_data,

    output logic           m_req_valid,
    input  logic           m_req_ready,
    output rdma_req_t      m_req_data,

    input  logic           s_ack_valid,
    output logic           s_ack_ready,
    input  rdma_ack_t      s_ack_data,

    output logic           push_valid,
    input  logic           push_ready,
    output rdma_ack_t      push_data,

    output session_key_t   tbl_addr,
    output logic           tbl_we,
    output session_entry_t tbl_wdata,
    input  session_entry_t tbl_rdata,
    input  logic           table_ready
);

    flow_state_t    state;
    flow_state_t    state_next;
    session_key_t   key_q;
    session_entry_t entry_q;
    session_key_t   req_key;
    session_key_t   ack_key;
    slot_t          tail_inc;
    logic           window_open;

    assign req_key = '{
        rd:     is_read_op(s_req_data.opcode),
        region: s_req_data.region,
        pid:    s_req_data.pid
    };

    assign ack_key = '{
        rd:     is_read_op(s_ack_data.opcode),
        region: s_ack_data.region,
        pid:    s_ack_data.pid
    };

    assign tail_inc    = entry_q.tail + slot_t'(1);
    assign window_open = !entry_q.issued || (entry_q.head != entry_q.tail);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Key and entry are held for the update phase
    always_ff @(posedge aclk) begin
        if (state == ST_IDLE) begin
            key_q <= tbl_addr;
        end
        if (state == ST_ACK_WAIT || state == ST_REQ_WAIT) begin
            entry_q <= tbl_rdata;
        end
    end

    always_comb begin
        state_next  = state;
        s_ack_ready = 1'b0;
        push_valid  = 1'b0;
        s_req_ready = 1'b0;
        m_req_valid = 1'b0;
        tbl_addr    = key_q;
        tbl_we      = 1'b0;
        tbl_wdata   = entry_q;

        case (state)
            ST_IDLE: begin
                tbl_addr = s_ack_valid ? ack_key : req_key;
                if (table_ready) begin
                    // Acks first, so windows keep draining
                    if (s_ack_valid) begin
                        s_ack_ready = push_ready;
                        push_valid  = s_ack_data.last;
                        if (push_ready) begin
                            state_next = ST_ACK_WAIT;
                        end
                    end else if (s_req_valid) begin
                        state_next = ST_REQ_WAIT;
                    end
                end
            end

            ST_ACK_WAIT: begin
                state_next = ST_ACK_UPDATE;
            end

            ST_REQ_WAIT: begin
                state_next = ST_REQ_ISSUE;
            end

            ST_ACK_UPDATE: begin
                tbl_we           = 1'b1;
                tbl_wdata.tail   = tail_inc;
                tbl_wdata.issued = (tail_inc == entry_q.head) ? 1'b0 : entry_q.issued;
                state_next       = ST_IDLE;
            end

            ST_REQ_ISSUE: begin
                if (window_open) begin
                    m_req_valid = 1'b1;
                    if (m_req_ready) begin
                        s_req_ready      = 1'b1;
                        tbl_we           = 1'b1;
                        tbl_wdata.head   = entry_q.head + slot_t'(1);
                        tbl_wdata.issued = 1'b1;
                        state_next       = ST_IDLE;
                    end
                end else begin
                    // Window full, let acks in
                    state_next = ST_IDLE;
                end
            end

            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_comb begin
        m_req_data      = s_req_data;
        m_req_data.offs = offs_t'(entry_q.head);
    end

    assign push_data = s_ack_data;

endmodule

// File: rdma_flow/session_table.sv
`timescale 1ns/1ps

module session_table
    import rdma_flow_pkg::*;
(
    input  logic           aclk,
    input  logic           aresetn,

    input  session_key_t   tbl_addr,
    input  logic           tbl_we,
    input  session_entry_t tbl_wdata,
    output session_entry_t tbl_rdata,
    output logic           table_ready
);

    localparam int KEY_BITS = $bits(session_key_t);

    session_entry_t      mem [N_SESSIONS];
    logic [KEY_BITS-1:0] sweep_cnt;

    // Clearing sweep, one entry per cycle
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sweep_cnt   <= '0;
            table_ready <= 1'b0;
        end else if (!table_ready) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (sweep_cnt == KEY_BITS'(N_SESSIONS - 1)) begin
                table_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!table_ready) begin
            mem[sweep_cnt] <= '0;
        end else if (tbl_we) begin
            mem[tbl_addr] <= tbl_wdata;
        end
        tbl_rdata <= mem[tbl_addr];
    end

endmodule

// File: rdma_flow_top.f
+incdir+common
common/rdma_meta_pkg.sv
common/rdma_flow_pkg.sv
rtl/ack_queue.sv
rdma_flow/session_table.sv
rdma_flow/rdma_flow.sv
rtl/rdma_flow_top.sv
bench/rdma_flow_checker.sv
bench/rdma_flow_top_tb.sv

// File: rtl/ack_queue.sv
`timescale 1ns/1ps

`include "rdma_settings.svh"

module ack_queue
    import rdma_meta_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,

    input  logic      push_valid,
    output logic      push_ready,
    input  rdma_ack_t push_data,

    output logic      m_ack_valid,
    input  logic      m_ack_ready,
    output rdma_ack_t m_ack_data
);

    localparam int DEPTH    = `RDMA_ACK_QDEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    rdma_ack_t           mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                do_push;
    logic                do_pop;

    assign push_ready  = (count != (PTR_BITS+1)'(DEPTH));
    assign m_ack_valid = (count != '0);
    assign m_ack_data  = mem[rd_ptr];

    assign do_push = push_valid && push_ready;
    assign do_pop  = m_ack_valid && m_ack_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: rtl/rdma_flow_top.sv
`timescale 1ns/1ps

module rdma_flow_top
    import rdma_meta_pkg::*, rdma_flow_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,

    input  logic      s_req_valid,
    output logic      s_req_ready,
    input  rdma_req_t s_req_data,

    output logic      m_req_valid,
    input  logic      m_req_ready,
    output rdma_req_t m_req_data,

    input  logic      s_ack_valid,
    output logic      s_ack_ready,
    input  rdma_ack_t s_ack_data,

    output logic      m_ack_valid,
    input  logic      m_ack_ready,
    output rdma_ack_t m_ack_data
);

    session_key_t   tbl_addr;
    logic           tbl_we;
    session_entry_t tbl_wdata;
    session_entry_t tbl_rdata;
    logic           table_ready;

    logic           push_valid;
    logic           push_ready;
    rdma_ack_t      push_data;

    rdma_flow rdma_flow_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_req_valid (s_req_valid),
        .s_req_ready (s_req_ready),
        .s_req_data  (s_req_data),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready),
        .m_req_data  (m_req_data),
        .s_ack_valid (s_ack_valid),
        .s_ack_ready (s_ack_ready),
        .s_ack_data  (s_ack_data),
        .push_valid  (push_valid),
        .push_ready  (push_ready),
        .push_data   (push_data),
        .tbl_addr    (tbl_addr),
        .tbl_we      (tbl_we),
        .tbl_wdata   (tbl_wdata),
        .tbl_rdata   (tbl_rdata),
        .table_ready (table_ready)
    );

    session_table session_table_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .tbl_addr    (tbl_addr),
        .tbl_we      (tbl_we),
        .tbl_wdata   (tbl_wdata),
        .tbl_rdata   (tbl_rdata),
        .table_ready (table_ready)
    );

    ack_queue ack_queue_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .push_valid  (push_valid),
        .push_ready  (push_ready),
        .push_data   (push_data),
        .m_ack_valid (m_ack_valid),
        .m_ack_ready (m_ack_ready),
        .m_ack_data  (m_ack_data)
    );

endmodule
